//--- hw/rnn_cfg.svh
`ifndef RNN_CFG_SVH
`define RNN_CFG_SVH

// word layout, Q16.16
`define RNN_FIXED_W      32
`define RNN_FRAC_W       16
`define RNN_PROD_W       64

// tanh table
`define RNN_LUT_ADDR_W   10
`define RNN_LUT_DEPTH    1024

// weights are stored scaled by 256
`define RNN_WEIGHT_SHIFT 8

`define RNN_ONE          32'sh0001_0000
`define RNN_HALF         32'sh0000_8000

// magnitude of 4.0 and up is past the table
`define RNN_SAT_BIT      18

`endif

//--- hw/rnn_pkg.sv
`default_nettype none
`include "rnn_cfg.svh"

package rnn_pkg;

	// signed Q16.16 word
	typedef logic signed [`RNN_FIXED_W-1:0] fixed_t;

	// full width product of two words
	typedef logic signed [`RNN_PROD_W-1:0] prod_t;

	typedef logic [`RNN_LUT_ADDR_W-1:0] lut_addr_t;

	typedef enum logic [1:0] {
		ACT_TANH    = 2'd0,
		ACT_SIGMOID = 2'd1,
		ACT_RELU    = 2'd2
	} act_op_e;

endpackage

`default_nettype wire

//--- hw/mac_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_cfg.svh"

module mac_stage import rnn_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire            in_valid_i,
	input  wire fixed_t    in_weight_i,
	input  wire fixed_t    in_feature_i,
	input  wire            in_first_i,
	input  wire            in_last_i,
	input  wire fixed_t    in_bias_i,
	input  wire act_op_e   in_op_i,
	input  wire            sum_ready_i,
	output logic           in_ready_o,
	output logic           sum_valid_o,
	output fixed_t         sum_o,
	output act_op_e        sum_op_o
);

	prod_t   prod;
	fixed_t  prod_mid;
	fixed_t  acc;
	fixed_t  acc_next;
	act_op_e op_q;
	logic    beat;

	// room for a new beat whenever the sum register can drain
	assign in_ready_o = !sum_valid_o || sum_ready_i;
	assign beat = in_valid_i && in_ready_o;

	assign prod = prod_t'(in_weight_i) * prod_t'(in_feature_i);
	// keep bits 47..16 of the product
	assign prod_mid = prod[`RNN_FIXED_W+`RNN_FRAC_W-1:`RNN_FRAC_W];

	// a first beat reseeds from the bias
	assign acc_next = (in_first_i ? in_bias_i : acc) + prod_mid;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
			sum_valid_o <= 1'b0;
		end else begin
			if (beat) begin
				acc <= acc_next;
			end
			if (beat && in_last_i) begin
				sum_valid_o <= 1'b1;
			end else if (sum_ready_i) begin
				sum_valid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat && in_first_i) begin
			op_q <= in_op_i;
		end
		if (beat && in_last_i) begin
			sum_o <= acc_next;
			// single-beat burst has no stored opcode yet
			sum_op_o <= in_first_i ? in_op_i : op_q;
		end
	end

	a_sum_hold: assert property (@(posedge clk) disable iff (rst)
		sum_valid_o && !sum_ready_i |=> sum_valid_o && $stable(sum_o) && $stable(sum_op_o));

endmodule

`default_nettype wire

//--- hw/tanh_lut.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_cfg.svh"

module tanh_lut import rnn_pkg::*; (
	input  wire            clk,
	input  wire            we_i,
	input  wire lut_addr_t waddr_i,
	input  wire fixed_t    wdata_i,
	input  wire            rd_en_i,
	input  wire lut_addr_t raddr_i,
	output fixed_t         rdata_lo_o,
	output fixed_t         rdata_hi_o
);

	fixed_t    mem [`RNN_LUT_DEPTH];
	lut_addr_t raddr_nx;
	logic      raddr_top;

	assign raddr_nx = raddr_i + 1'b1;
	assign raddr_top = &raddr_i;

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		if (rd_en_i) begin
			rdata_lo_o <= mem[raddr_i];
			// tanh is 1.0 just past the last entry
			rdata_hi_o <= raddr_top ? `RNN_ONE : mem[raddr_nx];
		end
	end

endmodule

`default_nettype wire

//--- hw/lut_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_cfg.svh"

module lut_stage import rnn_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire            sum_valid_i,
	input  wire fixed_t    sum_i,
	input  wire act_op_e   sum_op_i,
	input  wire            act_ready_i,
	input  wire            lut_we_i,
	input  wire lut_addr_t lut_addr_i,
	input  wire fixed_t    lut_data_i,
	output logic           sum_ready_o,
	output logic           act_valid_o,
	output fixed_t         tab_lo_o,
	output fixed_t         tab_hi_o,
	output logic [7:0]     frac_o,
	output logic           neg_o,
	output logic           sat_o,
	output fixed_t         relu_o,
	output act_op_e        act_op_o
);

	fixed_t                  x;
	fixed_t                  arg;
	logic [`RNN_FIXED_W-1:0] mag;
	lut_addr_t               idx;
	logic                    neg;
	logic                    take;

	assign sum_ready_o = !act_valid_o || act_ready_i;
	assign take = sum_valid_i && sum_ready_o;

	// undo the 1/256 weight scale
	assign x = sum_i >>> `RNN_WEIGHT_SHIFT;
	// sigmoid(x) runs through tanh(x/2)
	assign arg = (sum_op_i == ACT_SIGMOID) ? (x >>> 1) : x;

	assign neg = arg[`RNN_FIXED_W-1];
	assign mag = neg ? -arg : arg;
	assign idx = mag[`RNN_SAT_BIT-1 -: `RNN_LUT_ADDR_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			act_valid_o <= 1'b0;
		end else if (take) begin
			act_valid_o <= 1'b1;
		end else if (act_ready_i) begin
			act_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			frac_o <= mag[7:0];
			neg_o <= neg;
			sat_o <= |mag[`RNN_FIXED_W-1:`RNN_SAT_BIT];
			relu_o <= x[`RNN_FIXED_W-1] ? '0 : x;
			act_op_o <= sum_op_i;
		end
	end

	// table read lands together with the registers above
	tanh_lut u_lut (
		.clk        (clk),
		.we_i       (lut_we_i),
		.waddr_i    (lut_addr_i),
		.wdata_i    (lut_data_i),
		.rd_en_i    (take),
		.raddr_i    (idx),
		.rdata_lo_o (tab_lo_o),
		.rdata_hi_o (tab_hi_o)
	);

	a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) take |-> !lut_we_i);

endmodule

`default_nettype wire

//--- hw/interp_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_cfg.svh"

module interp_stage import rnn_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire          act_valid_i,
	input  wire fixed_t  tab_lo_i,
	input  wire fixed_t  tab_hi_i,
	input  wire [7:0]    frac_i,
	input  wire          neg_i,
	input  wire          sat_i,
	input  wire fixed_t  relu_i,
	input  wire act_op_e act_op_i,
	input  wire          out_ready_i,
	output logic         act_ready_o,
	output logic         out_valid_o,
	output fixed_t       out_data_o
);

	localparam int FRAC_BITS = `RNN_SAT_BIT - `RNN_LUT_ADDR_W;

	fixed_t diff;
	prod_t  step;
	fixed_t interp;
	fixed_t t;
	fixed_t t_signed;
	fixed_t result;
	logic   take;

	assign act_ready_o = !out_valid_o || out_ready_i;
	assign take = act_valid_i && act_ready_o;

	// linear step between neighbouring entries
	assign diff = tab_hi_i - tab_lo_i;
	assign step = prod_t'(diff) * prod_t'($signed({1'b0, frac_i}));
	assign interp = tab_lo_i + fixed_t'(step >>> FRAC_BITS);

	assign t = sat_i ? `RNN_ONE : interp;
	// tanh is odd
	assign t_signed = neg_i ? -t : t;

	always_comb begin
		case (act_op_i)
			ACT_SIGMOID: result = (t_signed >>> 1) + `RNN_HALF;
			ACT_RELU:    result = relu_i;
			default:     result = t_signed;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid_o <= 1'b0;
		end else if (take) begin
			out_valid_o <= 1'b1;
		end else if (out_ready_i) begin
			out_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_data_o <= result;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

//--- hw/dense_neuron.sv
`timescale 1ns/1ps
`default_nettype none

module dense_neuron import rnn_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire            in_valid_i,
	input  wire fixed_t    in_weight_i,
	input  wire fixed_t    in_feature_i,
	input  wire            in_first_i,
	input  wire            in_last_i,
	input  wire fixed_t    in_bias_i,
	input  wire act_op_e   in_op_i,
	input  wire            out_ready_i,
	input  wire            lut_we_i,
	input  wire lut_addr_t lut_addr_i,
	input  wire fixed_t    lut_data_i,
	output logic           in_ready_o,
	output logic           out_valid_o,
	output fixed_t         out_data_o
);

	// mac to lut
	logic    sum_valid;
	logic    sum_ready;
	fixed_t  sum;
	act_op_e sum_op;

	// lut to interp
	logic       act_valid;
	logic       act_ready;
	fixed_t     tab_lo;
	fixed_t     tab_hi;
	logic [7:0] frac;
	logic       neg;
	logic       sat;
	fixed_t     relu;
	act_op_e    act_op;

	mac_stage u_mac (
		.clk          (clk),
		.rst          (rst),
		.in_valid_i   (in_valid_i),
		.in_weight_i  (in_weight_i),
		.in_feature_i (in_feature_i),
		.in_first_i   (in_first_i),
		.in_last_i    (in_last_i),
		.in_bias_i    (in_bias_i),
		.in_op_i      (in_op_i),
		.sum_ready_i  (sum_ready),
		.in_ready_o   (in_ready_o),
		.sum_valid_o  (sum_valid),
		.sum_o        (sum),
		.sum_op_o     (sum_op)
	);

	lut_stage u_lut_stage (
		.clk         (clk),
		.rst         (rst),
		.sum_valid_i (sum_valid),
		.sum_i       (sum),
		.sum_op_i    (sum_op),
		.act_ready_i (act_ready),
		.lut_we_i    (lut_we_i),
		.lut_addr_i  (lut_addr_i),
		.lut_data_i  (lut_data_i),
		.sum_ready_o (sum_ready),
		.act_valid_o (act_valid),
		.tab_lo_o    (tab_lo),
		.tab_hi_o    (tab_hi),
		.frac_o      (frac),
		.neg_o       (neg),
		.sat_o       (sat),
		.relu_o      (relu),
		.act_op_o    (act_op)
	);

	interp_stage u_interp (
		.clk         (clk),
		.rst         (rst),
		.act_valid_i (act_valid),
		.tab_lo_i    (tab_lo),
		.tab_hi_i    (tab_hi),
		.frac_i      (frac),
		.neg_i       (neg),
		.sat_i       (sat),
		.relu_i      (relu),
		.act_op_i    (act_op),
		.out_ready_i (out_ready_i),
		.act_ready_o (act_ready),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_data_o)
	);

endmodule

`default_nettype wire

//--- dv/tb_dense_neuron.sv
`timescale 1ns/1ps
`default_nettype none
`include "rnn_cfg.svh"

module tb_dense_neuron import rnn_pkg::*; ();

	localparam logic [31:0] SEED = 32'hdb52_a41f;
	localparam int RESET_CYCLES = 5;
	// longest possible stimulus in beats over all sections below
	localparam int MAX_BEATS = 12*32 + 8*32 + 9*3 + 8*32 + 4*4 + 16*8 + 6;
	localparam int CYCLE_LIMIT = 4*MAX_BEATS + `RNN_LUT_DEPTH + RESET_CYCLES + 100;

	logic clk = 1'b0;
	logic rst;
	logic in_valid_i;
	fixed_t in_weight_i;
	fixed_t in_feature_i;
	logic in_first_i;
	logic in_last_i;
	fixed_t in_bias_i;
	act_op_e in_op_i;
	logic out_ready_i;
	logic lut_we_i;
	lut_addr_t lut_addr_i;
	fixed_t lut_data_i;
	logic in_ready_o;
	logic out_valid_o;
	fixed_t out_data_o;

	logic [31:0] rng = SEED;
	logic [31:0] stall_rng = SEED ^ 32'h5a5a_0f0f;
	logic stall_en = 1'b0;
	int cycle_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	int sent_count[3] = '{0, 0, 0};
	int got_count[3] = '{0, 0, 0};

	fixed_t lut_copy [`RNN_LUT_DEPTH];
	fixed_t exp_q[$];
	string exp_name_q[$];
	act_op_e exp_op_q[$];

	dense_neuron uut (
		.clk          (clk),
		.rst          (rst),
		.in_valid_i   (in_valid_i),
		.in_weight_i  (in_weight_i),
		.in_feature_i (in_feature_i),
		.in_first_i   (in_first_i),
		.in_last_i    (in_last_i),
		.in_bias_i    (in_bias_i),
		.in_op_i      (in_op_i),
		.out_ready_i  (out_ready_i),
		.lut_we_i     (lut_we_i),
		.lut_addr_i   (lut_addr_i),
		.lut_data_i   (lut_data_i),
		.in_ready_o   (in_ready_o),
		.out_valid_o  (out_valid_o),
		.out_data_o   (out_data_o)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// signed value spread over +/- 2^(bits-1)
	function automatic fixed_t rand_signed(input int bits);
		rng = xorshift32(rng);
		return fixed_t'($signed(rng) >>> (32 - bits));
	endfunction

	function automatic int rand_below(input int n);
		rng = xorshift32(rng);
		return int'(rng % n);
	endfunction

	// monotonic ramp from 0 up to 1.0 that bends like tanh
	function automatic fixed_t ramp_entry(input int i);
		int d;
		d = `RNN_LUT_DEPTH - i;
		return `RNN_ONE - fixed_t'((d * d) >>> 4);
	endfunction

	// expected activation of one accumulated sum
	function automatic fixed_t expected_out(input fixed_t sum, input act_op_e op);
		fixed_t x;
		fixed_t arg;
		fixed_t mag;
		fixed_t lo;
		fixed_t hi;
		fixed_t diff;
		fixed_t t;
		longint step;
		int idx;
		int fr;
		logic neg;
		logic sat;
		x = sum >>> `RNN_WEIGHT_SHIFT;
		arg = (op == ACT_SIGMOID) ? (x >>> 1) : x;
		neg = arg < 0;
		mag = neg ? -arg : arg;
		sat = mag[`RNN_FIXED_W-1:`RNN_SAT_BIT] != 0;
		idx = int'(mag[17:8]);
		fr = int'(mag[7:0]);
		lo = lut_copy[idx];
		hi = (idx == `RNN_LUT_DEPTH - 1) ? `RNN_ONE : lut_copy[idx + 1];
		diff = hi - lo;
		step = longint'(diff) * longint'(fr);
		t = sat ? `RNN_ONE : lo + fixed_t'(step >>> 8);
		if (neg) begin
			t = -t;
		end
		case (op)
			ACT_SIGMOID: return (t >>> 1) + `RNN_HALF;
			ACT_RELU:    return (x < 0) ? '0 : x;
			default:     return t;
		endcase
	endfunction

	task automatic check_value(input string name, input fixed_t exp, input fixed_t got);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic check_op_mix(input act_op_e op, input int exp_n, input int got_n);
		if (exp_n != got_n) begin
			value_errors++;
			$display("[FAIL] op_mix_%s expected %0d actual %0d", op.name(), exp_n, got_n);
		end
	endtask

	task automatic load_table();
		for (int i = 0; i < `RNN_LUT_DEPTH; i++) begin
			@(negedge clk);
			lut_we_i = 1'b1;
			lut_addr_i = lut_addr_t'(i);
			lut_data_i = ramp_entry(i);
			lut_copy[i] = ramp_entry(i);
		end
		@(negedge clk);
		lut_we_i = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			in_valid_i = 1'b0;
		end
	endtask

	// one neuron with noise on bias and op after the first beat
	task automatic send_burst(input string name, input act_op_e op, input fixed_t bias,
			input int len, input int w_bits);
		fixed_t acc;
		fixed_t w;
		fixed_t f;
		prod_t p;
		acc = '0;
		for (int i = 0; i < len; i++) begin
			w = rand_signed(w_bits);
			f = rand_signed(17);
			p = prod_t'(w) * prod_t'(f);
			acc = ((i == 0) ? bias : acc) + fixed_t'(p[`RNN_FIXED_W+`RNN_FRAC_W-1:`RNN_FRAC_W]);
			@(negedge clk);
			in_valid_i = 1'b1;
			in_weight_i = w;
			in_feature_i = f;
			in_first_i = (i == 0);
			in_last_i = (i == len - 1);
			in_bias_i = (i == 0) ? bias : rand_signed(32);
			in_op_i = (i == 0) ? op : act_op_e'(2'(rand_below(3)));
			if (i == len - 1) begin
				exp_q.push_back(expected_out(acc, op));
				exp_name_q.push_back(name);
				exp_op_q.push_back(op);
				sent_count[int'(op)]++;
			end
			do @(posedge clk); while (!in_ready_o);
		end
	endtask

	always @(negedge clk) begin
		if (stall_en) begin
			stall_rng = xorshift32(stall_rng);
			out_ready_i = stall_rng[7];
		end else begin
			out_ready_i = 1'b1;
		end
	end

	always @(posedge clk) begin : compare_results
		fixed_t e;
		string n;
		act_op_e o;
		if (!rst && out_ready_i && in_ready_o !== 1'b1) begin
			other_errors++;
			$display("in_ready_o is not high while out_ready_i is high");
		end
		if (!rst && out_valid_o && out_ready_i) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("result %h arrived with no neuron outstanding", out_data_o);
			end else begin
				e = exp_q.pop_front();
				n = exp_name_q.pop_front();
				o = exp_op_q.pop_front();
				if (out_data_o === e) begin
					got_count[int'(o)]++;
				end
				check_value(n, e, out_data_o);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d results still missing",
				cycle_count, exp_q.size());
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		in_valid_i = 1'b0;
		in_weight_i = '0;
		in_feature_i = '0;
		in_first_i = 1'b0;
		in_last_i = 1'b0;
		in_bias_i = '0;
		in_op_i = ACT_TANH;
		out_ready_i = 1'b1;
		lut_we_i = 1'b0;
		lut_addr_i = '0;
		lut_data_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		load_table();
		if (out_valid_o !== 1'b0) begin
			other_errors++;
			$display("out_valid_o is not low after reset and table load");
		end

		for (int k = 0; k < 12; k++) begin
			send_burst("tanh_rand", ACT_TANH, rand_signed(26), 1 + rand_below(32), 21);
		end
		for (int k = 0; k < 8; k++) begin
			send_burst("sigmoid_rand", ACT_SIGMOID, rand_signed(26), 1 + rand_below(32), 21);
		end
		// clearly negative sums
		for (int k = 0; k < 9; k++) begin
			send_burst("relu_neg", ACT_RELU, -32'sh0200_0000, 3, 17);
		end
		for (int k = 0; k < 8; k++) begin
			send_burst("relu_rand", ACT_RELU, rand_signed(26), 1 + rand_below(32), 21);
		end
		// 12.0 after scaling is past the table for tanh and sigmoid
		send_burst("tanh_sat_pos", ACT_TANH, 32'sh0C00_0000, 4, 17);
		send_burst("tanh_sat_neg", ACT_TANH, -32'sh0C00_0000, 4, 17);
		send_burst("sigmoid_sat_pos", ACT_SIGMOID, 32'sh0C00_0000, 4, 17);
		send_burst("sigmoid_sat_neg", ACT_SIGMOID, -32'sh0C00_0000, 4, 17);

		stall_en = 1'b1;
		for (int k = 0; k < 16; k++) begin
			send_burst("stall_mix", act_op_e'(2'(k % 3)), rand_signed(26), 1 + rand_below(8), 21);
			if (rand_below(2) == 0) begin
				idle_cycles(1 + rand_below(2));
			end
		end
		stall_en = 1'b0;

		for (int k = 0; k < 6; k++) begin
			send_burst("single_beat", act_op_e'(2'(k % 3)), rand_signed(26), 1, 21);
		end
		idle_cycles(1);

		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		for (int k = 0; k < 3; k++) begin
			check_op_mix(act_op_e'(2'(k)), sent_count[k], got_count[k]);
		end

		$display("errors: value %0d, other %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/rnn_pkg.sv
hw/mac_stage.sv
hw/tanh_lut.sv
hw/lut_stage.sv
hw/interp_stage.sv
hw/dense_neuron.sv
dv/tb_dense_neuron.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dense_neuron
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := sim failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
